/* Bender.yml */
package:
  name: cpu_core

sources:
  # design
  - cpu_pkg.sv
  - stage_reg.sv
  - decode.sv
  - execute.sv
  - hazard_ctrl.sv
  - cpu_core.sv
  # testbench
  - target: test
    files:
      - cpu_core_props.sv
      - tb_cpu_core.sv

/* cpu_core.sv */
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    input  instr_t  in_instr,
    output logic    in_ready,
    output logic    result_valid,
    output result_t result,
    input  logic    result_ready
);

    ////////////////////////////////////////////////////////////
    ////////////////////////// wires ///////////////////////////
    ////////////////////////////////////////////////////////////

    // hazard control
    logic              stall;
    logic              flush;
    logic              accept;
    logic              taken;
    logic [SKIP_W-1:0] skip;
    // decode out, execute in
    logic              de_valid;
    de_ex_t            de_data;
    logic              ex_in_valid;
    de_ex_t            ex_in;
    // execute out
    logic              ex_out_valid;
    result_t           ex_out;
    // register write happens on the output handshake
    logic              res_fire;

    assign res_fire = result_valid && result_ready;

    hazard_ctrl u_hazard (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .taken        (taken),
        .skip         (skip),
        .in_ready     (in_ready),
        .accept       (accept),
        .stall        (stall),
        .flush        (flush)
    );

    decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (accept),
        .in_instr  (in_instr),
        .wr_valid  (res_fire),
        .wr        (result),
        .out_valid (de_valid),
        .out       (de_data)
    );

    stage_reg #(.payload_t(de_ex_t)) u_de_ex (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .flush     (flush),
        .in_valid  (de_valid),
        .in_data   (de_data),
        .out_valid (ex_in_valid),
        .out_data  (ex_in)
    );

    execute u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .in_valid  (ex_in_valid),
        .in        (ex_in),
        .fwd_valid (result_valid),
        .fwd       (result),
        .out_valid (ex_out_valid),
        .out       (ex_out),
        .taken     (taken),
        .skip      (skip)
    );

    // the branch itself carries no write, so nothing here to flush
    stage_reg #(.payload_t(result_t)) u_ex_res (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .flush     (1'b0),
        .in_valid  (ex_out_valid),
        .in_data   (ex_out),
        .out_valid (result_valid),
        .out_data  (result)
    );

endmodule

/* cpu_core_props.sv */
`timescale 1ns/1ps

module cpu_core_props import cpu_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    input logic    in_ready,
    input logic    result_valid,
    input logic    result_ready,
    input result_t result
);

    // idle outputs while reset is held
    a_reset_idle: assert property (@(posedge clk) !rst_n |-> !result_valid && in_ready)
        else $error("result_valid high or in_ready low during reset");

    // first edge after release
    a_release_idle: assert property (@(posedge clk) $rose(rst_n) |-> !result_valid && in_ready)
        else $error("result_valid high or in_ready low after reset release");

    // payload frozen under back-pressure
    a_result_hold: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && !result_ready |=> result_valid && $stable(result))
        else $error("result dropped or changed while result_ready was low");

endmodule

bind cpu_core cpu_core_props u_props (.*);

/* cpu_pkg.sv */
package cpu_pkg;

    ////////////////////////////////////////////////////////////
    ////////////////////////// widths //////////////////////////
    ////////////////////////////////////////////////////////////

    // datapath width
    localparam int XLEN       = 32;
    // register index and register count
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    // immediate field, sign extended to XLEN
    localparam int IMM_W      = 12;
    // branch discard count, low bits of imm
    localparam int SKIP_W     = 4;

    ////////////////////////////////////////////////////////////
    ///////////////////////// opcodes //////////////////////////
    ////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        OP_NOP  = 5'd0,
        // register ALU ops
        OP_ADD  = 5'd1,
        OP_SUB  = 5'd2,
        OP_AND  = 5'd3,
        OP_OR   = 5'd4,
        OP_XOR  = 5'd5,
        // rs1 plus sign-extended imm
        OP_ADDI = 5'd6,
        // subtract, flags only
        OP_CMP  = 5'd7,
        // flag conditioned branches
        OP_BEQ  = 5'd8,
        OP_BNE  = 5'd9,
        OP_BLT  = 5'd10,
        OP_BGE  = 5'd11,
        // unconditional
        OP_JMP  = 5'd12
    } alu_op_e;

    ////////////////////////////////////////////////////////////
    ///////////////////////// payloads /////////////////////////
    ////////////////////////////////////////////////////////////

    // instruction word, opcode in the top bits
    typedef struct packed {
        alu_op_e               opcode;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [IMM_W-1:0]      imm;
    } instr_t;

    // N high, Z low
    typedef struct packed {
        logic n;
        logic z;
    } flags_t;

    // decode to execute
    typedef struct packed {
        alu_op_e               op;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       rs1_val;
        logic [XLEN-1:0]       rs2_val;
        logic [XLEN-1:0]       imm;
        logic                  use_imm;
        logic                  wr_en;
        logic                  set_flags;
        logic                  is_branch;
        logic [SKIP_W-1:0]     skip;
    } de_ex_t;

    // one register write
    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } result_t;

endpackage

/* decode.sv */
`timescale 1ns/1ps

module decode import cpu_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    input  instr_t  in_instr,
    input  logic    wr_valid,
    input  result_t wr,
    output logic    out_valid,
    output de_ex_t  out
);

    logic [XLEN-1:0] regs [NUM_REGS];
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;

    ////////////////////////////////////////////////////////////
    ////////////////////// register file ///////////////////////
    ////////////////////////////////////////////////////////////

    // wr_valid is already the result handshake
    // r0 is never written and stays zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_valid && wr.rd != '0) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // operand read with write-through
    // a write landing this edge is seen at once
    always_comb begin
        if (in_instr.rs1 == '0) begin
            rs1_val = '0;
        end else if (wr_valid && wr.rd == in_instr.rs1) begin
            rs1_val = wr.data;
        end else begin
            rs1_val = regs[in_instr.rs1];
        end
        if (in_instr.rs2 == '0) begin
            rs2_val = '0;
        end else if (wr_valid && wr.rd == in_instr.rs2) begin
            rs2_val = wr.data;
        end else begin
            rs2_val = regs[in_instr.rs2];
        end
    end

    ////////////////////////////////////////////////////////////
    ////////////////////// control decode //////////////////////
    ////////////////////////////////////////////////////////////

    always_comb begin
        out         = '0;
        out.op      = in_instr.opcode;
        out.rs1     = in_instr.rs1;
        out.rs2     = in_instr.rs2;
        out.rd      = in_instr.rd;
        out.rs1_val = rs1_val;
        out.rs2_val = rs2_val;
        // sign extend
        out.imm     = {{(XLEN-IMM_W){in_instr.imm[IMM_W-1]}}, in_instr.imm};
        // discard count for branches
        out.skip    = in_instr.imm[SKIP_W-1:0];
        case (in_instr.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                out.wr_en     = 1'b1;
                out.set_flags = 1'b1;
            end
            OP_ADDI: begin
                out.wr_en     = 1'b1;
                out.set_flags = 1'b1;
                out.use_imm   = 1'b1;
            end
            // flags only, no write
            OP_CMP: begin
                out.set_flags = 1'b1;
            end
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_JMP: begin
                out.is_branch = 1'b1;
            end
            // OP_NOP and unused codes do nothing
            default: begin
                out.wr_en = 1'b0;
            end
        endcase
        // writes to r0 vanish here
        if (in_instr.rd == '0) begin
            out.wr_en = 1'b0;
        end
    end

    // accept from hazard_ctrl, already qualified
    assign out_valid = in_valid;

endmodule

/* execute.sv */
`timescale 1ns/1ps

module execute import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  logic              in_valid,
    input  de_ex_t            in,
    input  logic              fwd_valid,
    input  result_t           fwd,
    output logic              out_valid,
    output result_t           out,
    output logic              taken,
    output logic [SKIP_W-1:0] skip
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] rs2_fwd;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_out;
    flags_t          flags_d;
    flags_t          flags_q;
    logic            cond;

    ////////////////////////////////////////////////////////////
    //////////////////////// forwarding ////////////////////////
    ////////////////////////////////////////////////////////////

    // result stage holds the next older write
    // anything older was bypassed in decode
    always_comb begin
        op_a = in.rs1_val;
        if (fwd_valid && in.rs1 != '0 && fwd.rd == in.rs1) begin
            op_a = fwd.data;
        end
        rs2_fwd = in.rs2_val;
        if (fwd_valid && in.rs2 != '0 && fwd.rd == in.rs2) begin
            rs2_fwd = fwd.data;
        end
        // immediate replaces rs2 for ADDI
        op_b = in.use_imm ? in.imm : rs2_fwd;
    end

    ////////////////////////////////////////////////////////////
    /////////////////////////// alu ////////////////////////////
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (in.op)
            OP_ADD, OP_ADDI: alu_out = op_a + op_b;
            // CMP is a SUB without the write
            OP_SUB, OP_CMP:  alu_out = op_a - op_b;
            OP_AND:          alu_out = op_a & op_b;
            OP_OR:           alu_out = op_a | op_b;
            OP_XOR:          alu_out = op_a ^ op_b;
            default:         alu_out = '0;
        endcase
    end

    // sign bit and zero detect
    assign flags_d.n = alu_out[XLEN-1];
    assign flags_d.z = (alu_out == '0);

    // single flag register
    // updates on the edge that loads the result stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags_q <= '0;
        end else if (in_valid && !stall && in.set_flags) begin
            flags_q <= flags_d;
        end
    end

    ////////////////////////////////////////////////////////////
    //////////////////// branch resolution /////////////////////
    ////////////////////////////////////////////////////////////

    // conditions use flags from older instructions only
    always_comb begin
        case (in.op)
            OP_BEQ:  cond = flags_q.z;
            OP_BNE:  cond = !flags_q.z;
            OP_BLT:  cond = flags_q.n;
            OP_BGE:  cond = !flags_q.n;
            OP_JMP:  cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    assign taken = in_valid && in.is_branch && cond;
    assign skip  = in.skip;

    // only register writes go downstream
    assign out_valid = in_valid && in.wr_en;
    assign out.rd    = in.rd;
    assign out.data  = alu_out;

endmodule

/* hazard_ctrl.sv */
`timescale 1ns/1ps

module hazard_ctrl import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  logic              result_valid,
    input  logic              result_ready,
    input  logic              taken,
    input  logic [SKIP_W-1:0] skip,
    output logic              in_ready,
    output logic              accept,
    output logic              stall,
    output logic              flush
);

    logic [SKIP_W-1:0] skip_cnt;
    logic              xfer;

    // output back-pressure freezes the whole pipe
    assign stall    = result_valid && !result_ready;
    assign in_ready = !stall;
    assign xfer     = in_valid && in_ready;

    // a zero-count branch has nothing to drop
    assign flush = taken && !stall && (skip != '0);

    // transfers while skipping are swallowed
    assign accept = xfer && (skip_cnt == '0) && !flush;

    // discard counter
    // the instruction taken in the flush cycle is the first discard
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            skip_cnt <= '0;
        end else if (flush) begin
            skip_cnt <= xfer ? skip - 1'b1 : skip;
        end else if (xfer && skip_cnt != '0) begin
            skip_cnt <= skip_cnt - 1'b1;
        end
    end

endmodule

/* src.f */
cpu_pkg.sv
stage_reg.sv
decode.sv
execute.sv
hazard_ctrl.sv
cpu_core.sv
cpu_core_props.sv
tb_cpu_core.sv

/* stage_reg.sv */
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // valid bit
    // stall freezes, flush turns the load into a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_valid <= in_valid && !flush;
        end
    end

    // payload, only meaningful under out_valid
    always_ff @(posedge clk) begin
        if (!stall) begin
            out_data <= in_data;
        end
    end

endmodule

/* tb_cpu_core.sv */
`timescale 1ns/1ps

module tb_cpu_core import cpu_pkg::*; ();

    localparam int CLK_PERIOD   = 4;
    localparam int RST_CYCLES   = 8;
    localparam int DRAIN_CYCLES = 4;
    localparam int BP_LEN       = 48;
    // alu, forwarding, taken, not taken, back-pressure program lengths
    localparam int TOTAL_INSTR  = 16 + 9 + 41 + 28 + BP_LEN;
    // generous cycles per instruction with ready toggling
    localparam int STALL_FACTOR = 8;
    localparam int LIMIT_CYCLES = RST_CYCLES + TOTAL_INSTR * STALL_FACTOR
                                  + 5 * (DRAIN_CYCLES + 4);

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    instr_t  in_instr;
    logic    in_ready;
    logic    result_valid;
    result_t result;
    logic    result_ready;

    logic    bp_on;
    logic [31:0] lfsr_q = 32'h8cee4af4;
    instr_t  prog [$];
    result_t exp_q [$];
    // sequential model state
    logic [XLEN-1:0] m_regs [NUM_REGS];
    flags_t  m_flags;
    int      m_skip;

    cpu_core u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_instr     (in_instr),
        .in_ready     (in_ready),
        .result_valid (result_valid),
        .result       (result),
        .result_ready (result_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    ////////////////////// stimulus helpers ////////////////////
    ////////////////////////////////////////////////////////////

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic rand_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], rand_bit()};
        end
        return v;
    endfunction

    function automatic instr_t encode(input alu_op_e op, input int rd, input int rs1,
                                      input int rs2, input int imm);
        instr_t ins;
        ins.opcode = op;
        ins.rd     = REG_ADDR_W'(rd);
        ins.rs1    = REG_ADDR_W'(rs1);
        ins.rs2    = REG_ADDR_W'(rs2);
        ins.imm    = IMM_W'(imm);
        return ins;
    endfunction

    ////////////////////////////////////////////////////////////
    ///////////////////// reference model //////////////////////
    ////////////////////////////////////////////////////////////

    // in-order execution, one instruction at a time
    task automatic model_exec(input instr_t ins);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] val;
        logic            jump;
        result_t         r;
        // discarded by an earlier taken branch
        if (m_skip != 0) begin
            m_skip--;
            return;
        end
        a = m_regs[ins.rs1];
        b = (ins.opcode == OP_ADDI) ? {{(XLEN-IMM_W){ins.imm[IMM_W-1]}}, ins.imm}
                                    : m_regs[ins.rs2];
        case (ins.opcode)
            OP_ADD, OP_ADDI: val = a + b;
            OP_SUB, OP_CMP:  val = a - b;
            OP_AND:          val = a & b;
            OP_OR:           val = a | b;
            OP_XOR:          val = a ^ b;
            default:         val = '0;
        endcase
        if (ins.opcode inside {[OP_ADD:OP_CMP]}) begin
            m_flags.n = val[XLEN-1];
            m_flags.z = (val == '0);
        end
        // r0 stays zero, no result for it
        if (ins.opcode inside {[OP_ADD:OP_ADDI]} && ins.rd != '0) begin
            m_regs[ins.rd] = val;
            r.rd   = ins.rd;
            r.data = val;
            exp_q.push_back(r);
        end
        case (ins.opcode)
            OP_BEQ:  jump = m_flags.z;
            OP_BNE:  jump = !m_flags.z;
            OP_BLT:  jump = m_flags.n;
            OP_BGE:  jump = !m_flags.n;
            OP_JMP:  jump = 1'b1;
            default: jump = 1'b0;
        endcase
        if (jump) begin
            m_skip = ins.imm[SKIP_W-1:0];
        end
    endtask

    ////////////////////////////////////////////////////////////
    ////////////////////////// checks //////////////////////////
    ////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_result(input result_t got, input result_t want);
        if (got !== want) begin
            $display("ERROR result: got rd=%h data=%h, expected rd=%h data=%h",
                     got.rd, got.data, want.rd, want.data);
            abort_run();
        end
    endtask

    // send prog in order, compare every output transfer
    task automatic run_prog();
        int      idx;
        logic    held;
        result_t held_val;
        idx  = 0;
        held = 1'b0;
        foreach (prog[i]) begin
            model_exec(prog[i]);
        end
        while (idx < prog.size() || exp_q.size() != 0) begin
            @(negedge clk);
            in_valid = (idx < prog.size());
            // instruction held until it transfers
            if (in_valid) begin
                in_instr = prog[idx];
            end
            result_ready = bp_on ? rand_bit() : 1'b1;
            // sample mid low phase, values seen by the next rising edge
            #1;
            if (held && (!result_valid || result !== held_val)) begin
                $display("result dropped or changed while result_ready was low");
                abort_run();
            end
            held     = result_valid && !result_ready;
            held_val = result;
            if (result_valid && result_ready) begin
                if (exp_q.size() == 0) begin
                    $display("result transfer that the model does not expect");
                    abort_run();
                end
                check_result(result, exp_q.pop_front());
            end
            if (in_valid && in_ready) begin
                idx++;
            end
        end
        // pipe must go quiet
        @(negedge clk);
        in_valid     = 1'b0;
        result_ready = 1'b1;
        repeat (DRAIN_CYCLES) begin
            #1;
            if (result_valid) begin
                $display("extra result after the expected sequence");
                abort_run();
            end
            @(negedge clk);
        end
        prog.delete();
    endtask

    ////////////////////////////////////////////////////////////
    ////////////////////////// tests ///////////////////////////
    ////////////////////////////////////////////////////////////

    task automatic test_alu();
        // random seeds in r1..r8
        for (int r = 1; r <= 8; r++) begin
            prog.push_back(encode(OP_ADDI, r, 0, 0, int'(rand_bits(IMM_W))));
        end
        prog.push_back(encode(OP_ADD, 9, 1, 2, 0));
        prog.push_back(encode(OP_SUB, 10, 3, 4, 0));
        prog.push_back(encode(OP_AND, 11, 5, 6, 0));
        prog.push_back(encode(OP_OR, 12, 7, 8, 0));
        prog.push_back(encode(OP_XOR, 13, 1, 8, 0));
        prog.push_back(encode(OP_ADDI, 14, 5, 0, -300));
        // write to r0, no result
        prog.push_back(encode(OP_ADD, 0, 1, 2, 0));
        prog.push_back(encode(OP_ADDI, 15, 0, 0, 77));
        run_prog();
    endtask

    task automatic test_forwarding();
        prog.push_back(encode(OP_ADD, 16, 1, 2, 0));
        // distance 1
        prog.push_back(encode(OP_ADD, 17, 16, 3, 0));
        // distances 2 and 1
        prog.push_back(encode(OP_SUB, 18, 16, 17, 0));
        prog.push_back(encode(OP_XOR, 19, 17, 4, 0));
        prog.push_back(encode(OP_ADDI, 19, 19, 0, 5));
        prog.push_back(encode(OP_ADD, 20, 19, 19, 0));
        prog.push_back(encode(OP_ADD, 21, 1, 3, 0));
        // distance 2 across a nop
        prog.push_back(encode(OP_NOP, 0, 0, 0, 0));
        prog.push_back(encode(OP_OR, 21, 21, 2, 0));
        run_prog();
    endtask

    // cmp, branch with count k, then k plus two writes
    task automatic branch_case(input alu_op_e op, input int ra, input int rb, input int k);
        prog.push_back(encode(OP_CMP, 0, ra, rb, 0));
        prog.push_back(encode(op, 0, 0, 0, k));
        for (int i = 0; i < k + 2; i++) begin
            prog.push_back(encode(OP_ADDI, 24 + i % 8, 0, 0, int'(rand_bits(IMM_W))));
        end
    endtask

    task automatic test_branch_taken();
        // r22 negative, r23 positive
        prog.push_back(encode(OP_ADDI, 22, 0, 0, -5));
        prog.push_back(encode(OP_ADDI, 23, 0, 0, 3));
        branch_case(OP_BEQ, 1, 1, 1);
        branch_case(OP_BNE, 22, 23, 2);
        branch_case(OP_BLT, 22, 23, 3);
        branch_case(OP_BGE, 23, 22, 4);
        branch_case(OP_JMP, 1, 2, 5);
        branch_case(OP_JMP, 1, 2, 0);
        run_prog();
    endtask

    task automatic test_branch_not_taken();
        branch_case(OP_BEQ, 22, 23, 3);
        branch_case(OP_BNE, 1, 1, 3);
        branch_case(OP_BLT, 23, 22, 3);
        branch_case(OP_BGE, 22, 23, 3);
        run_prog();
    endtask

    task automatic test_backpressure();
        alu_op_e op;
        int      imm;
        for (int i = 0; i < BP_LEN; i++) begin
            op  = alu_op_e'(rand_bits(4) % 12 + 1);
            // short discard counts for branches
            imm = (op >= OP_BEQ) ? rand_bits(2) : rand_bits(IMM_W);
            prog.push_back(encode(op, int'(rand_bits(4)), int'(rand_bits(4)),
                                  int'(rand_bits(4)), imm));
        end
        bp_on = 1'b1;
        run_prog();
        bp_on = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    ////////////////////////// main ////////////////////////////
    ////////////////////////////////////////////////////////////

    initial begin
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_instr     = '0;
        result_ready = 1'b0;
        bp_on        = 1'b0;
        m_flags      = '0;
        m_skip       = 0;
        foreach (m_regs[i]) begin
            m_regs[i] = '0;
        end
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        if (result_valid || !in_ready) begin
            $display("outputs not idle after reset");
            abort_run();
        end
        test_alu();
        test_forwarding();
        test_branch_taken();
        test_branch_not_taken();
        test_backpressure();
        $display("Test OK");
        $finish;
    end

    // limit from total program length
    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("watchdog expired before all tests finished");
        $display("Test FAILED");
        $fatal(1, "timeout");
    end

endmodule
